//--- verilog/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

// fetch group geometry
localparam int FETCH_NUM        = 2;
localparam int FETCH_WIDTH      = $clog2(FETCH_NUM);
// low address bits below the group boundary
localparam int ADDR_ALIGN_WIDTH = FETCH_WIDTH + 2;

typedef logic [31:0] virt_t;
typedef logic [31:0] instr_t;

// first byte of the fetch group that holds addr
function automatic virt_t group_align(input virt_t addr);
	return {addr[31:ADDR_ALIGN_WIDTH], {ADDR_ALIGN_WIDTH{1'b0}}};
endfunction

endpackage

`default_nettype wire

//--- verilog/pc_generator.sv
`timescale 1ns/100ps
`default_nettype none

module pc_generator #(
	parameter cpu_pkg::virt_t RESET_VECTOR = 32'hbfc0_0000
)(
	input  logic           clk,
	input  logic           rst_n,
	input  logic           hold,
	input  logic           full,
	input  logic           except_valid,
	input  cpu_pkg::virt_t except_vec,
	input  logic           resolved_valid,
	input  logic           resolved_mispredict,
	input  logic           resolved_taken,
	input  cpu_pkg::virt_t resolved_pc,
	input  cpu_pkg::virt_t resolved_target,
	input  logic           predict_valid,
	input  cpu_pkg::virt_t predict_vaddr,
	output cpu_pkg::virt_t pc,
	output logic           redirect,
	output cpu_pkg::virt_t redirect_vaddr
);

import cpu_pkg::*;

localparam virt_t GROUP_BYTES = virt_t'(FETCH_NUM * 4);

logic mispredict;

assign mispredict = resolved_valid && resolved_mispredict;
assign redirect   = except_valid || mispredict;

// exception beats misprediction
always_comb begin
	if (except_valid) begin
		redirect_vaddr = except_vec;
	end else if (resolved_taken) begin
		redirect_vaddr = resolved_target;
	end else begin
		redirect_vaddr = resolved_pc + 32'd4;
	end
end

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		pc <= RESET_VECTOR;
	end else if (redirect) begin
		pc <= group_align(redirect_vaddr) + GROUP_BYTES;
	end else if (predict_valid) begin
		// stage 2 drops this fetch when full, so refetch the target
		if (full) begin
			pc <= predict_vaddr;
		end else begin
			pc <= group_align(predict_vaddr) + GROUP_BYTES;
		end
	end else if (!(hold || full)) begin
		pc <= group_align(pc) + GROUP_BYTES;
	end
end

a_redirect_source: assert property (@(posedge clk) disable iff (!rst_n)
	redirect |-> (except_valid || (resolved_valid && resolved_mispredict)))
	else $error("redirect without exception or misprediction");

endmodule

`default_nettype wire

//--- verilog/branch_predictor.sv
`timescale 1ns/100ps
`default_nettype none

module branch_predictor #(
	parameter int BTB_SIZE = 8
)(
	input  logic                          clk,
	input  logic                          rst_n,
	input  cpu_pkg::virt_t                group_vaddr,
	input  logic [cpu_pkg::FETCH_NUM-1:0] slot_valid,
	input  logic                          resolved_valid,
	input  logic                          resolved_taken,
	input  cpu_pkg::virt_t                resolved_pc,
	input  cpu_pkg::virt_t                resolved_target,
	output logic                          predict_valid,
	output cpu_pkg::virt_t                predict_vaddr,
	output logic [cpu_pkg::FETCH_NUM-1:0] slot_hit
);

import cpu_pkg::*;

// word address bits pick the entry, the rest is tag
localparam int IDX_W = $clog2(BTB_SIZE);
localparam int TAG_W = 32 - IDX_W - 2;

logic [BTB_SIZE-1:0] btb_valid;
logic [TAG_W-1:0]    btb_tag    [BTB_SIZE];
virt_t               btb_target [BTB_SIZE];

logic [IDX_W-1:0] res_idx;
logic [TAG_W-1:0] res_tag;
virt_t            group_base;
logic [FETCH_NUM-1:0] raw_hit;
virt_t            slot_target [FETCH_NUM];

assign res_idx    = resolved_pc[IDX_W+1:2];
assign res_tag    = resolved_pc[31:IDX_W+2];
assign group_base = group_align(group_vaddr);

// training, taken installs and not taken evicts
always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		btb_valid <= '0;
	end else if (resolved_valid) begin
		if (resolved_taken) begin
			btb_valid[res_idx] <= 1'b1;
		end else if (btb_tag[res_idx] == res_tag) begin
			btb_valid[res_idx] <= 1'b0;
		end
	end
end

always_ff @(posedge clk) begin
	if (resolved_valid && resolved_taken) begin
		btb_tag[res_idx]    <= res_tag;
		btb_target[res_idx] <= resolved_target;
	end
end

// one lookup per slot of the group
for (genvar i = 0; i < FETCH_NUM; i++) begin : gen_lookup
	virt_t            slot_vaddr;
	logic [IDX_W-1:0] slot_idx;

	assign slot_vaddr     = group_base + virt_t'(4 * i);
	assign slot_idx       = slot_vaddr[IDX_W+1:2];
	assign raw_hit[i]     = btb_valid[slot_idx] &&
	                        (btb_tag[slot_idx] == slot_vaddr[31:IDX_W+2]);
	assign slot_target[i] = btb_target[slot_idx];
end

assign slot_hit = raw_hit & slot_valid;

// lowest hitting slot wins
always_comb begin
	predict_valid = 1'b0;
	predict_vaddr = '0;
	for (int i = 0; i < FETCH_NUM; i++) begin
		if (slot_hit[i] && !predict_valid) begin
			predict_valid = 1'b1;
			predict_vaddr = slot_target[i];
		end
	end
end

a_predict_slot: assert property (@(posedge clk) disable iff (!rst_n)
	predict_valid |-> |slot_valid)
	else $error("prediction from an invalid slot");

endmodule

`default_nettype wire

//--- verilog/instr_queue.sv
`timescale 1ns/100ps
`default_nettype none

module instr_queue #(
	parameter int QUEUE_DEPTH = 8
)(
	input  logic                                      clk,
	input  logic                                      rst_n,
	input  logic                                      flush,
	input  logic [cpu_pkg::FETCH_NUM-1:0]             push_valid,
	input  cpu_pkg::virt_t                            push_base,
	input  cpu_pkg::instr_t [cpu_pkg::FETCH_NUM-1:0]  push_instr,
	input  logic                                      fetch_ack,
	output logic                                      full,
	output logic                                      fetch_valid,
	output cpu_pkg::virt_t                            fetch_vaddr,
	output cpu_pkg::instr_t                           fetch_instr
);

import cpu_pkg::*;

localparam int PTR_W = $clog2(QUEUE_DEPTH);

typedef logic [PTR_W-1:0] ptr_t;
typedef logic [PTR_W:0]   cnt_t;

virt_t  mem_vaddr [QUEUE_DEPTH];
instr_t mem_instr [QUEUE_DEPTH];

ptr_t head;
ptr_t tail;
cnt_t count;
cnt_t push_num;
ptr_t wr_ptr [FETCH_NUM];
logic pop;

// room for one more group in flight
assign full = (cnt_t'(QUEUE_DEPTH) - count) < cnt_t'(2 * FETCH_NUM);

assign fetch_valid = (count != '0);
assign fetch_vaddr = mem_vaddr[head];
assign fetch_instr = mem_instr[head];
assign pop         = fetch_valid && fetch_ack;

// valid slots pack into consecutive entries from tail
always_comb begin
	push_num = '0;
	for (int i = 0; i < FETCH_NUM; i++) begin
		wr_ptr[i] = tail + ptr_t'(push_num);
		push_num  = push_num + cnt_t'(push_valid[i]);
	end
end

always_ff @(posedge clk) begin
	for (int i = 0; i < FETCH_NUM; i++) begin
		if (push_valid[i]) begin
			mem_vaddr[wr_ptr[i]] <= push_base + virt_t'(4 * i);
			mem_instr[wr_ptr[i]] <= push_instr[i];
		end
	end
end

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		head  <= '0;
		tail  <= '0;
		count <= '0;
	end else if (flush) begin
		head  <= '0;
		tail  <= '0;
		count <= '0;
	end else begin
		tail  <= tail + ptr_t'(push_num);
		head  <= head + ptr_t'(pop);
		count <= count + push_num - cnt_t'(pop);
	end
end

a_occupancy: assert property (@(posedge clk) disable iff (!rst_n)
	count <= cnt_t'(QUEUE_DEPTH))
	else $error("queue occupancy above depth");

// full must throttle stage 2 early enough for the last group
a_push_fits: assert property (@(posedge clk) disable iff (!rst_n)
	!flush |-> push_num <= cnt_t'(QUEUE_DEPTH) - count + cnt_t'(pop))
	else $error("push into a queue without room");

endmodule

`default_nettype wire

//--- verilog/instr_fetch.sv
`timescale 1ns/100ps
`default_nettype none

module instr_fetch #(
	parameter int             BTB_SIZE     = 8,
	parameter int             QUEUE_DEPTH  = 8,
	parameter cpu_pkg::virt_t RESET_VECTOR = 32'hbfc0_0000
)(
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             stall,

	// exception
	input  logic                             except_valid,
	input  cpu_pkg::virt_t                   except_vec,

	// branch resolution from execute
	input  logic                             resolved_valid,
	input  cpu_pkg::virt_t                   resolved_pc,
	input  logic                             resolved_taken,
	input  cpu_pkg::virt_t                   resolved_target,
	input  logic                             resolved_mispredict,

	// instruction cache
	output cpu_pkg::virt_t                   icache_addr,
	input  logic [cpu_pkg::FETCH_NUM*32-1:0] icache_data,

	// decode
	input  logic                             fetch_ack,
	output logic                             fetch_valid,
	output cpu_pkg::virt_t                   fetch_vaddr,
	output cpu_pkg::instr_t                  fetch_instr
);

import cpu_pkg::*;

virt_t pc;
virt_t redirect_vaddr;
virt_t predict_vaddr;
virt_t s1_vaddr;
virt_t s2_vaddr;
logic  redirect;
logic  predict_valid;
logic  full;
logic  s2_valid;

logic [FETCH_WIDTH-1:0] s2_offset;
logic [FETCH_NUM-1:0]   pre_valid;
logic [FETCH_NUM-1:0]   slot_hit;
logic [FETCH_NUM-1:0]   slot_valid;
instr_t [FETCH_NUM-1:0] s2_instr;

// stage 1 fetch address
always_comb begin
	if (redirect) begin
		s1_vaddr = redirect_vaddr;
	end else if (predict_valid) begin
		s1_vaddr = predict_vaddr;
	end else if (stall) begin
		// re-request the held group
		s1_vaddr = s2_vaddr;
	end else begin
		s1_vaddr = pc;
	end
end

assign icache_addr = group_align(s1_vaddr);

pc_generator #(
	.RESET_VECTOR ( RESET_VECTOR )
) pc_gen_inst (
	.clk,
	.rst_n,
	.hold ( stall ),
	.full,
	.except_valid,
	.except_vec,
	.resolved_valid,
	.resolved_mispredict,
	.resolved_taken,
	.resolved_pc,
	.resolved_target,
	.predict_valid,
	.predict_vaddr,
	.pc,
	.redirect,
	.redirect_vaddr
);

// stage 1/2 register, unaligned address keeps the slot offset
always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		s2_vaddr <= RESET_VECTOR;
		s2_valid <= 1'b0;
	end else if (redirect) begin
		s2_vaddr <= s1_vaddr;
		s2_valid <= 1'b1;
	end else if (!stall) begin
		s2_vaddr <= s1_vaddr;
		s2_valid <= !full;
	end
end

// stage 2 slot masking
assign s2_offset = s2_vaddr[ADDR_ALIGN_WIDTH-1:2];
assign s2_instr  = icache_data;

always_comb begin
	for (int i = 0; i < FETCH_NUM; i++) begin
		pre_valid[i] = s2_valid && !stall && (i >= int'(s2_offset));
	end
end

// predicted branch keeps its slot, later slots go
always_comb begin
	logic hit_before;

	hit_before = 1'b0;
	for (int i = 0; i < FETCH_NUM; i++) begin
		slot_valid[i] = pre_valid[i] && !hit_before;
		hit_before    = hit_before || slot_hit[i];
	end
end

branch_predictor #(
	.BTB_SIZE ( BTB_SIZE )
) bp_inst (
	.clk,
	.rst_n,
	.group_vaddr ( s2_vaddr  ),
	.slot_valid  ( pre_valid ),
	.resolved_valid,
	.resolved_taken,
	.resolved_pc,
	.resolved_target,
	.predict_valid,
	.predict_vaddr,
	.slot_hit
);

instr_queue #(
	.QUEUE_DEPTH ( QUEUE_DEPTH )
) ique_inst (
	.clk,
	.rst_n,
	.flush      ( redirect              ),
	.push_valid ( slot_valid            ),
	.push_base  ( group_align(s2_vaddr) ),
	.push_instr ( s2_instr              ),
	.fetch_ack,
	.full,
	.fetch_valid,
	.fetch_vaddr,
	.fetch_instr
);

endmodule

`default_nettype wire

//--- sim/tb_instr_fetch.sv
`timescale 1ns/100ps
`default_nettype none

module tb_instr_fetch;

import cpu_pkg::*;

localparam virt_t RESET_VECTOR   = 32'hbfc0_0000;
localparam int    BTB_SIZE       = 8;
localparam int    QUEUE_DEPTH    = 8;
localparam int    IDX_W          = $clog2(BTB_SIZE);
localparam int    RESET_CYCLES   = 8;
localparam int    NUM_CHECKS     = 600;
// plain sequential stream before any redirect
localparam int    QUIET_CHECKS   = 40;
localparam int    TIMEOUT_CYCLES = RESET_CYCLES + NUM_CHECKS * 20;
// targets stay in a small region so branches form loops
localparam virt_t REGION         = 32'h0000_1000;

logic                    clk;
logic                    rst_n;
logic                    stall;
logic                    except_valid;
virt_t                   except_vec;
logic                    resolved_valid;
virt_t                   resolved_pc;
logic                    resolved_taken;
virt_t                   resolved_target;
logic                    resolved_mispredict;
virt_t                   icache_addr;
logic [FETCH_NUM*32-1:0] icache_data = '0;
logic                    fetch_ack;
logic                    fetch_valid;
virt_t                   fetch_vaddr;
instr_t                  fetch_instr;

logic [31:0] lfsr;
int          ack_hold;
int          consumed;
virt_t       exp_vaddr;

// mirror of the btb
bit    ref_valid  [BTB_SIZE];
virt_t ref_pc     [BTB_SIZE];
virt_t ref_target [BTB_SIZE];

instr_fetch #(
	.BTB_SIZE     ( BTB_SIZE     ),
	.QUEUE_DEPTH  ( QUEUE_DEPTH  ),
	.RESET_VECTOR ( RESET_VECTOR )
) dut0 (
	.clk                 ( clk                 ),
	.rst_n               ( rst_n               ),
	.stall               ( stall               ),
	.except_valid        ( except_valid        ),
	.except_vec          ( except_vec          ),
	.resolved_valid      ( resolved_valid      ),
	.resolved_pc         ( resolved_pc         ),
	.resolved_taken      ( resolved_taken      ),
	.resolved_target     ( resolved_target     ),
	.resolved_mispredict ( resolved_mispredict ),
	.icache_addr         ( icache_addr         ),
	.icache_data         ( icache_data         ),
	.fetch_ack           ( fetch_ack           ),
	.fetch_valid         ( fetch_valid         ),
	.fetch_vaddr         ( fetch_vaddr         ),
	.fetch_instr         ( fetch_instr         )
);

// memory contents, address scrambled and rotated left by 7
function automatic instr_t mem_word(input virt_t addr);
	virt_t x;

	x = addr ^ 32'h1234_5678;
	return {x[24:0], x[31:25]};
endfunction

// address after a consumed instruction, btb hit means taken
function automatic virt_t expected_next(input virt_t addr);
	logic [IDX_W-1:0] idx;

	idx = addr[IDX_W+1:2];
	if (ref_valid[idx] && ref_pc[idx] == addr) begin
		return ref_target[idx];
	end
	return addr + 32'd4;
endfunction

function automatic virt_t region_word(input logic [5:0] w);
	return REGION + {24'd0, w, 2'b00};
endfunction

// fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

task automatic take_bits(input int n, output logic [31:0] bits);
	bits = '0;
	for (int i = 0; i < n; i++) begin
		lfsr = lfsr_step(lfsr);
		bits = {bits[30:0], lfsr[0]};
	end
endtask

task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
	if (got !== exp) begin
		$display("FAIL at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		$display("TEST RESULT: FAIL");
		$fatal(1, "fetch stream mismatch");
	end
endtask

// one redirect, decode not acknowledging in this cycle
task automatic send_event();
	logic [31:0]      r;
	logic [IDX_W-1:0] idx;

	fetch_ack = 1'b0;
	take_bits(2, r);
	if (r[1:0] == 2'd0) begin
		take_bits(6, r);
		except_valid = 1'b1;
		except_vec   = region_word(r[5:0]);
	end else if (r[1:0] != 2'd3) begin
		// backward branch, odd target words included
		take_bits(10, r);
		resolved_valid      = 1'b1;
		resolved_mispredict = 1'b1;
		resolved_taken      = 1'b1;
		resolved_pc         = region_word({1'b1, r[4:0]});
		resolved_target     = region_word({1'b0, r[9:5]});
	end else begin
		// not taken, prefer a branch that is in the btb
		take_bits(IDX_W + 5, r);
		idx                 = r[IDX_W-1:0];
		resolved_valid      = 1'b1;
		resolved_mispredict = 1'b1;
		resolved_taken      = 1'b0;
		if (ref_valid[idx]) begin
			resolved_pc = ref_pc[idx];
		end else begin
			resolved_pc = region_word({1'b1, r[IDX_W+4:IDX_W]});
		end
	end
endtask

task automatic drive_cycle();
	logic [31:0] r;

	except_valid        = 1'b0;
	resolved_valid      = 1'b0;
	resolved_mispredict = 1'b0;
	take_bits(3, r);
	stall = (r[2:0] == 3'd0);
	if (ack_hold > 0) begin
		ack_hold--;
		fetch_ack = 1'b0;
	end else begin
		take_bits(5, r);
		if (r[4:0] == 5'd0) begin
			// long decode back-pressure
			take_bits(4, r);
			ack_hold  = 8 + int'(r[3:0]);
			fetch_ack = 1'b0;
		end else begin
			take_bits(2, r);
			fetch_ack = (r[1:0] != 2'd0);
		end
	end
	if (consumed >= QUIET_CHECKS) begin
		take_bits(5, r);
		if (r[4:0] == 5'd0) begin
			send_event();
		end
	end
endtask

initial clk = 1'b0;
always #5 clk = ~clk;

// cache answers one cycle after the request
always @(posedge clk) begin
	for (int i = 0; i < FETCH_NUM; i++) begin
		icache_data[32*i +: 32] <= mem_word(group_align(icache_addr) + virt_t'(4 * i));
	end
end

always @(posedge clk) begin : ref_model
	logic [IDX_W-1:0] idx;

	if (!rst_n) begin
		exp_vaddr = RESET_VECTOR;
		consumed  = 0;
		for (int i = 0; i < BTB_SIZE; i++) begin
			ref_valid[i] = 1'b0;
		end
	end else begin
		if (fetch_valid && fetch_ack) begin
			check_equal(fetch_vaddr, exp_vaddr, "fetch_vaddr");
			check_equal(fetch_instr, mem_word(exp_vaddr), "fetch_instr");
			exp_vaddr = expected_next(exp_vaddr);
			consumed++;
		end
		if (except_valid) begin
			exp_vaddr = except_vec;
		end else if (resolved_valid && resolved_mispredict) begin
			if (resolved_taken) begin
				exp_vaddr = resolved_target;
			end else begin
				exp_vaddr = resolved_pc + 32'd4;
			end
		end
		// btb training, same edge as the hardware
		idx = resolved_pc[IDX_W+1:2];
		if (resolved_valid) begin
			if (resolved_taken) begin
				ref_valid[idx]  = 1'b1;
				ref_pc[idx]     = resolved_pc;
				ref_target[idx] = resolved_target;
			end else if (ref_pc[idx] == resolved_pc) begin
				ref_valid[idx] = 1'b0;
			end
		end
	end
end

initial begin
	repeat (TIMEOUT_CYCLES) @(posedge clk);
	$display("timeout: fetch stopped delivering instructions");
	$display("TEST RESULT: FAIL");
	$fatal(1, "watchdog expired");
end

initial begin
	lfsr                = 32'hd995;
	ack_hold            = 0;
	rst_n               = 1'b0;
	stall               = 1'b0;
	except_valid        = 1'b0;
	except_vec          = '0;
	resolved_valid      = 1'b0;
	resolved_pc         = '0;
	resolved_taken      = 1'b0;
	resolved_target     = '0;
	resolved_mispredict = 1'b0;
	fetch_ack           = 1'b0;
	repeat (RESET_CYCLES) @(negedge clk);
	rst_n = 1'b1;
	while (consumed < NUM_CHECKS) begin
		@(negedge clk);
		drive_cycle();
	end
	$display("TEST RESULT: PASS");
	$finish;
end

endmodule

`default_nettype wire

//--- instr_fetch.f
verilog/cpu_pkg.sv
verilog/pc_generator.sv
verilog/branch_predictor.sv
verilog/instr_queue.sv
verilog/instr_fetch.sv
sim/tb_instr_fetch.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the instr_fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_instr_fetch -f instr_fetch.f -Mdir obj_dir; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vtb_instr_fetch)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "TEST RESULT: PASS" <<< "$sim_out"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1
